/* Makefile */
SOURCES := $(shell cat all.f)

obj_dir/VuartTb: all.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module uartTb -f all.f

.PHONY: run clean

run: obj_dir/VuartTb
	@out=$$(./obj_dir/VuartTb); echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

/* all.f */
src/uartPkg.sv
src/baudTickGen.sv
src/uartRx.sv
src/uartTx.sv
src/byteFifo.sv
src/uartRegs.sv
src/uartTop.sv
test/uartTb.sv

/* src/baudTickGen.sv */
//////////////////////////////////////////////////
// oversampling tick source, one sTick per divisor+1 clocks
//////////////////////////////////////////////////
`timescale 1ns/1ps

module baudTickGen (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] divisor,
	output logic       sTick
);

	logic [7:0] count;       // down counter
	logic [7:0] lastDivisor; // divisor the count was loaded from
	logic       divChanged;

	assign divChanged = (divisor != lastDivisor);

	// tick on zero, suppressed in the restart cycle
	assign sTick = (count == 8'd0) && !divChanged;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			count       <= 8'd0;
			lastDivisor <= 8'd0;
		end
		else if (divChanged)
		begin
			// restart at once, no leftover long period
			count       <= divisor;
			lastDivisor <= divisor;
		end
		else if (count == 8'd0)
			count <= divisor;       // reload after the tick
		else
			count <= count - 8'd1;
	end

endmodule

/* src/byteFifo.sv */
//////////////////////////////////////////////////
// byte FIFO with valid/ready on both sides, used once
// for the receive path and once for the transmit path
//////////////////////////////////////////////////
`timescale 1ns/1ps

module byteFifo
	import uartPkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                inValid,
	input  logic [dataBits-1:0] inData,
	output logic                inReady,
	output logic                outValid,
	output logic [dataBits-1:0] outData,
	input  logic                outReady,
	output logic                full,
	output logic                notEmpty
);

	logic [dataBits-1:0]   mem [fifoDepth];
	logic [fifoAddrBits:0] wrPtr, rdPtr;   // extra msb tells full from empty
	logic                  empty;
	logic                  push, pop;

	assign empty = (wrPtr == rdPtr);
	assign full  = (wrPtr[fifoAddrBits] != rdPtr[fifoAddrBits])
		&& (wrPtr[fifoAddrBits-1:0] == rdPtr[fifoAddrBits-1:0]);

	assign inReady  = !full;
	assign outValid = !empty;
	assign notEmpty = !empty;
	assign outData  = mem[rdPtr[fifoAddrBits-1:0]]; // head of queue

	assign push = inValid && inReady;
	assign pop  = outValid && outReady;   // may coincide with push

	//////////////////////////////////////////////////
	// pointers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr[fifoAddrBits-1:0]] <= inData;
	end

	// full queue is never written, so the write side stands still
	assert property (@(posedge clk) disable iff (reset)
		full |=> (wrPtr == $past(wrPtr)));

	// empty queue is never read, so the read side stands still
	assert property (@(posedge clk) disable iff (reset)
		empty |=> (rdPtr == $past(rdPtr)));

endmodule

/* src/uartPkg.sv */
//////////////////////////////////////////////////
// shared constants, register words and stream types
// for the UART peripheral, imported by its modules
//////////////////////////////////////////////////

package uartPkg;

	//////////////////////////////////////////////////
	// frame and buffer sizes
	localparam int dataBits      = 8;   // bits per frame
	localparam int oversample    = 16;  // ticks per bit
	localparam int startMidTicks = 7;   // idle edge to start-bit middle
	localparam int stopTicks     = 16;  // one stop bit
	localparam int fifoDepth     = 16;
	localparam int fifoAddrBits  = 4;   // log2 of fifoDepth

	localparam logic [7:0] divisorReset = 8'd53;

	// register map
	localparam logic [1:0] regCtrl    = 2'd0; // read/write
	localparam logic [1:0] regDivisor = 2'd1; // read/write
	localparam logic [1:0] regStatus  = 2'd2; // read only

	//////////////////////////////////////////////////
	// register words
	typedef struct packed {
		logic       rxEnable;
		logic       txEnable;
		logic       loopback;    // tx line feeds rx internally
		logic       clearErrors; // self clearing, reads 0
		logic [3:0] reserved;
	} uartCtrl_t;

	// one write word, two meanings by address
	typedef union packed {
		uartCtrl_t  ctrl;
		logic [7:0] divisor;
	} regWord_u;

	typedef struct packed {
		logic       write;
		logic [1:0] addr;
		regWord_u   wdata;
	} regReq_t;

	typedef struct packed {
		logic       rxNotEmpty;
		logic       txFull;
		logic       txIdle;
		logic       frameError; // sticky
		logic       overrun;    // sticky
		logic [2:0] reserved;
	} uartStatus_t;

	// valid/ready byte transfer, ready runs against valid
	typedef struct packed {
		logic                valid;
		logic                ready;
		logic [dataBits-1:0] data;
	} byteStream_t;

endpackage

/* src/uartRegs.sv */
//////////////////////////////////////////////////
// control and divisor registers, sticky error flags,
// status readback with a one-cycle read response
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uartRegs
	import uartPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       reqValid,
	input  regReq_t    req,
	output logic       respValid,
	output logic [7:0] respData,
	output logic [7:0] divisor,
	output uartCtrl_t  ctrl,
	input  logic       rxDone,
	input  logic       frameError,
	input  logic       rxFull,
	input  logic       rxNotEmpty,
	input  logic       txFull,
	input  logic       txIdle
);

	uartCtrl_t   ctrlReg;
	logic [7:0]  divisorReg;
	logic        frameErrFlag, overrunFlag;
	uartStatus_t status;
	logic        wrCtrl, wrDivisor, rdReq, clearReq;
	logic        badFrame, lostByte;

	assign wrCtrl    = reqValid && req.write && (req.addr == regCtrl);
	assign wrDivisor = reqValid && req.write && (req.addr == regDivisor);
	assign rdReq     = reqValid && !req.write;
	assign clearReq  = wrCtrl && req.wdata.ctrl.clearErrors; // control view of word

	// receive events, only counted while the receiver is on
	assign badFrame = rxDone && ctrlReg.rxEnable && frameError;
	assign lostByte = rxDone && ctrlReg.rxEnable && !frameError && rxFull;

	//////////////////////////////////////////////////
	// writable registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ctrlReg    <= '0;           // everything off
			divisorReg <= divisorReset;
		end
		else
		begin
			if (wrCtrl)
			begin
				ctrlReg             <= req.wdata.ctrl;
				ctrlReg.clearErrors <= 1'b0; // strobe, never held
				ctrlReg.reserved    <= '0;
			end
			if (wrDivisor)
				divisorReg <= req.wdata.divisor; // divisor view of word
		end
	end

	// sticky flags, a new event beats a clear in the same cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			frameErrFlag <= 1'b0;
			overrunFlag  <= 1'b0;
		end
		else
		begin
			if (clearReq)
			begin
				frameErrFlag <= 1'b0;
				overrunFlag  <= 1'b0;
			end
			if (badFrame)
				frameErrFlag <= 1'b1;
			if (lostByte)
				overrunFlag <= 1'b1;
		end
	end

	always_comb
	begin
		status            = '0;
		status.rxNotEmpty = rxNotEmpty;
		status.txFull     = txFull;
		status.txIdle     = txIdle;
		status.frameError = frameErrFlag;
		status.overrun    = overrunFlag;
	end

	//////////////////////////////////////////////////
	// read response, one cycle after the request
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			respValid <= 1'b0;
		else
			respValid <= rdReq;
	end

	always_ff @(posedge clk)
	begin
		if (rdReq)
			case (req.addr)
				regCtrl:    respData <= ctrlReg;
				regDivisor: respData <= divisorReg;
				regStatus:  respData <= status;
				default:    respData <= 8'd0;  // unmapped address
			endcase
	end

	assign divisor = divisorReg;
	assign ctrl    = ctrlReg;

endmodule

/* src/uartRx.sv */
//////////////////////////////////////////////////
// serial receiver that samples each bit at its middle on the
// 16x tick and reports a byte with a one-cycle rxDone
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uartRx
	import uartPkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                rx,
	output logic                rxDone,
	output logic                frameError,
	output logic [dataBits-1:0] rxByte
);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} rxState_t;

	rxState_t            state, stateNext;
	logic [3:0]          tickCnt, tickNext; // ticks within a bit
	logic [3:0]          bitCnt, bitNext;   // data bit index
	logic [dataBits-1:0] shiftReg, shiftNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= stIdle;
			tickCnt  <= '0;
			bitCnt   <= '0;
			shiftReg <= '0;
		end
		else
		begin
			state    <= stateNext;
			tickCnt  <= tickNext;
			bitCnt   <= bitNext;
			shiftReg <= shiftNext;
		end
	end

	//////////////////////////////////////////////////
	// next state
	always_comb
	begin
		stateNext  = state;
		tickNext   = tickCnt;
		bitNext    = bitCnt;
		shiftNext  = shiftReg;
		rxDone     = 1'b0;
		frameError = 1'b0;
		case (state)
			stIdle:
				if (!rx)                    // falling edge may be a start bit
				begin
					stateNext = stStart;
					tickNext  = '0;
				end
			stStart:
				if (sTick)
				begin
					if (tickCnt == 4'(startMidTicks))
					begin
						tickNext  = '0;
						bitNext   = '0;
						// high again at mid start means a glitch
						stateNext = rx ? stIdle : stData;
					end
					else
						tickNext = tickCnt + 4'd1;
				end
			stData:
				if (sTick)
				begin
					if (tickCnt == 4'(oversample - 1)) // middle of next data bit
					begin
						tickNext  = '0;
						shiftNext = {rx, shiftReg[dataBits-1:1]}; // lsb first
						if (bitCnt == 4'(dataBits - 1))
							stateNext = stStop;
						else
							bitNext = bitCnt + 4'd1;
					end
					else
						tickNext = tickCnt + 4'd1;
				end
			stStop:
				if (sTick)
				begin
					if (tickCnt == 4'(stopTicks - 1)) // stop bit sampled here
					begin
						rxDone     = 1'b1;
						frameError = !rx;              // stop must be high
						stateNext  = stIdle;           // idle waits out the line
					end
					else
						tickNext = tickCnt + 4'd1;
				end
			default:
				stateNext = stIdle;
		endcase
	end

	assign rxByte = shiftReg;

	// done only on a stop tick
	assert property (@(posedge clk) disable iff (reset)
		rxDone |-> (state == stStop) && sTick);

	// bit index never runs past the last data bit
	assert property (@(posedge clk) disable iff (reset) bitCnt <= 4'(dataBits - 1));

endmodule

/* src/uartTop.sv */
//////////////////////////////////////////////////
// UART peripheral top, register port plus tx and rx byte streams
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uartTop
	import uartPkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                rx,
	output logic                tx,
	input  logic                reqValid,
	input  regReq_t             req,
	output logic                respValid,
	output logic [7:0]          respData,
	input  logic                txValid,
	input  logic [dataBits-1:0] txData,
	output logic                txReady,
	output logic                rxValid,
	output logic [dataBits-1:0] rxData,
	input  logic                rxReady
);

	logic                sTick;
	logic [7:0]          divisor;
	uartCtrl_t           ctrl;
	logic                rxIn, txLine;
	logic                rxDone, rxFrameError;
	logic [dataBits-1:0] rxByte;
	logic                rxPush, rxFull, rxNotEmpty;
	logic                txFull, txIdle;
	byteStream_t         txFeed;   // tx FIFO head to transmitter

	assign rxIn   = ctrl.loopback ? txLine : rx; // loopback select
	assign tx     = txLine;
	assign rxPush = rxDone && !rxFrameError && ctrl.rxEnable; // good bytes only

	baudTickGen baudGen (
		.clk(clk), .reset(reset), .divisor(divisor), .sTick(sTick)
	);

	uartRx receiver (
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rxIn),
		.rxDone(rxDone), .frameError(rxFrameError), .rxByte(rxByte)
	);

	// push is a pulse, a full FIFO simply drops it
	byteFifo rxFifo (
		.clk(clk), .reset(reset), .inValid(rxPush), .inData(rxByte), .inReady(),
		.outValid(rxValid), .outData(rxData), .outReady(rxReady),
		.full(rxFull), .notEmpty(rxNotEmpty)
	);

	byteFifo txFifo (
		.clk(clk), .reset(reset), .inValid(txValid), .inData(txData), .inReady(txReady),
		.outValid(txFeed.valid), .outData(txFeed.data), .outReady(txFeed.ready),
		.full(txFull), .notEmpty()
	);

	uartTx transmitter (
		.clk(clk), .reset(reset), .sTick(sTick), .enable(ctrl.txEnable),
		.inValid(txFeed.valid), .inData(txFeed.data), .inReady(txFeed.ready),
		.tx(txLine), .idle(txIdle)
	);

	uartRegs regs (
		.clk(clk), .reset(reset), .reqValid(reqValid), .req(req),
		.respValid(respValid), .respData(respData), .divisor(divisor), .ctrl(ctrl),
		.rxDone(rxDone), .frameError(rxFrameError), .rxFull(rxFull),
		.rxNotEmpty(rxNotEmpty), .txFull(txFull), .txIdle(txIdle)
	);

endmodule

/* src/uartTx.sv */
//////////////////////////////////////////////////
// serial transmitter that takes a byte when idle and shifts out
// start, 8 data bits lsb first and stop on the 16x tick
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uartTx
	import uartPkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                enable,
	input  logic                inValid,
	input  logic [dataBits-1:0] inData,
	output logic                inReady,
	output logic                tx,
	output logic                idle
);

	typedef enum logic [1:0] {stIdle, stStart, stData, stStop} txState_t;

	txState_t            state, stateNext;
	logic [3:0]          tickCnt, tickNext;
	logic [2:0]          bitCnt, bitNext;
	logic [dataBits-1:0] shiftReg, shiftNext;
	logic                txReg, txNext;   // registered line avoids glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= stIdle;
			tickCnt  <= '0;
			bitCnt   <= '0;
			shiftReg <= '0;
			txReg    <= 1'b1;   // line idles high
		end
		else
		begin
			state    <= stateNext;
			tickCnt  <= tickNext;
			bitCnt   <= bitNext;
			shiftReg <= shiftNext;
			txReg    <= txNext;
		end
	end

	assign idle    = (state == stIdle);
	assign inReady = idle && enable;
	assign tx      = txReg;

	//////////////////////////////////////////////////
	// next state
	always_comb
	begin
		stateNext = state;
		tickNext  = tickCnt;
		bitNext   = bitCnt;
		shiftNext = shiftReg;
		txNext    = txReg;
		case (state)
			stIdle:
				if (inValid && enable)   // byte accepted
				begin
					stateNext = stStart;
					tickNext  = '0;
					shiftNext = inData;
					txNext    = 1'b0;     // start bit from next cycle
				end
			stStart:
				if (sTick)
				begin
					if (tickCnt == 4'(oversample - 1))
					begin
						stateNext = stData;
						tickNext  = '0;
						bitNext   = '0;
						txNext    = shiftReg[0];
					end
					else
						tickNext = tickCnt + 4'd1;
				end
			stData:
				if (sTick)
				begin
					if (tickCnt == 4'(oversample - 1))
					begin
						tickNext  = '0;
						shiftNext = shiftReg >> 1;
						if (bitCnt == 3'(dataBits - 1))
						begin
							stateNext = stStop;
							txNext    = 1'b1;  // stop bit
						end
						else
						begin
							bitNext = bitCnt + 3'd1;
							txNext  = shiftReg[1]; // next bit up
						end
					end
					else
						tickNext = tickCnt + 4'd1;
				end
			stStop:
				if (sTick)
				begin
					if (tickCnt == 4'(stopTicks - 1))
						stateNext = stIdle;
					else
						tickNext = tickCnt + 4'd1;
				end
			default:
				stateNext = stIdle;
		endcase
	end

	// line is marking whenever nothing is being sent
	assert property (@(posedge clk) disable iff (reset) idle |-> tx);

endmodule

/* test/uartTb.sv */
//////////////////////////////////////////////////
// directed testbench for the UART top, drives the register
// port, both byte streams and a serial line model on rx/tx
//////////////////////////////////////////////////
`timescale 1ns/1ps

module uartTb
	import uartPkg::*;
();

	localparam int frameCount    = 30;                  // all frames of all tests, rounded up
	localparam int frameClocks   = 10 * oversample * 2; // one frame at divisor 1
	localparam int timeoutCycles = 2 * frameCount * frameClocks + 1000;

	logic                clk, reset;
	logic                rx, tx;
	logic                reqValid;
	regReq_t             req;
	logic                respValid;
	logic [7:0]          respData;
	logic                txValid, txReady;
	logic [dataBits-1:0] txData;
	logic                rxValid, rxReady;
	logic [dataBits-1:0] rxData;

	int         errorCount;
	int         checkCount;
	int         cycleCount = 0;
	int         bitClocks;    // clocks per serial bit at the current divisor
	integer     seed;
	logic       sawTxStall;   // txReady seen low while pushing
	logic [7:0] sent [$];     // bytes sent in the running test

	uartTop DUT (
		.clk(clk), .reset(reset), .rx(rx), .tx(tx),
		.reqValid(reqValid), .req(req), .respValid(respValid), .respData(respData),
		.txValid(txValid), .txData(txData), .txReady(txReady),
		.rxValid(rxValid), .rxData(rxData), .rxReady(rxReady)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog, sized from the frame count
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
			$display("Testbench failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// helpers, all start and end 1 ns after a rising edge
	task automatic waitClocks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic checkValue(input logic [7:0] got, input logic [7:0] expected,
		input string what);
		checkCount++;
		assert (got === expected)
		else
		begin
			errorCount++;
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	function automatic logic [7:0] ctrlWord(input logic rxEn, input logic txEn,
		input logic loop, input logic clear);
		uartCtrl_t word;
		word             = '0;
		word.rxEnable    = rxEn;
		word.txEnable    = txEn;
		word.loopback    = loop;
		word.clearErrors = clear;
		return word;
	endfunction

	task automatic writeReg(input logic [1:0] addr, input logic [7:0] value);
		reqValid = 1'b1;
		req      = {1'b1, addr, value};
		waitClocks(1);          // accepted on this edge
		reqValid = 1'b0;
		req      = '0;
	endtask

	task automatic readReg(input logic [1:0] addr, output logic [7:0] value);
		reqValid = 1'b1;
		req      = {1'b0, addr, 8'd0};
		waitClocks(1);
		reqValid = 1'b0;
		req      = '0;
		checkCount++;
		assert (respValid === 1'b1)   // response due exactly one cycle later
		else
		begin
			errorCount++;
			$display("read of register %0d got no response one cycle after the request",
				addr);
		end
		value = respData;
	endtask

	task automatic setDivisor(input logic [7:0] value);
		writeReg(regDivisor, value);
		bitClocks = oversample * (int'(value) + 1);
	endtask

	// repeat status reads until a masked bit is set
	task automatic pollStatus(input logic [7:0] mask, output logic [7:0] value);
		readReg(regStatus, value);
		while ((value & mask) == 8'd0)
			readReg(regStatus, value);
	endtask

	task automatic pushTx(input logic [7:0] value);
		txValid = 1'b1;
		txData  = value;
		while (!txReady)        // hold valid and data, FIFO full
		begin
			sawTxStall = 1'b1;
			waitClocks(1);
		end
		waitClocks(1);          // transfer edge
		txValid = 1'b0;
	endtask

	task automatic popRx(output logic [7:0] value);
		rxReady = 1'b1;
		while (!rxValid)
			waitClocks(1);
		value = rxData;
		waitClocks(1);
		rxReady = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// serial line model
	task automatic sendFrame(input logic [7:0] value, input logic stopLevel);
		rx = 1'b0;                             // start bit
		waitClocks(bitClocks);
		for (int i = 0; i < dataBits; i++)
		begin
			rx = value[i];                     // lsb first
			waitClocks(bitClocks);
		end
		rx = stopLevel;
		waitClocks(bitClocks);
		rx = 1'b1;                             // idle
	endtask

	task automatic decodeFrame(output logic [7:0] value);
		value = '0;
		while (tx)                             // wait for the start edge
			waitClocks(1);
		waitClocks(bitClocks / 2);             // middle of start bit
		checkValue(8'(tx), 8'd0, "tx start bit level");
		for (int i = 0; i < dataBits; i++)
		begin
			waitClocks(bitClocks);
			value[i] = tx;
		end
		waitClocks(bitClocks);
		checkValue(8'(tx), 8'd1, "tx stop bit level");
	endtask

	//////////////////////////////////////////////////
	// directed tests
	task automatic resetState();
		uartStatus_t expStatus;
		logic [7:0]  value;
		expStatus        = '0;
		expStatus.txIdle = 1'b1;               // nothing queued
		checkValue(8'(tx), 8'd1, "tx level after reset");
		checkValue(8'(rxValid), 8'd0, "rxValid after reset");
		checkValue(8'(respValid), 8'd0, "respValid after reset");
		checkValue(8'(txReady), 8'd1, "txReady after reset");
		readReg(regCtrl, value);
		checkValue(value, 8'd0, "control after reset");
		readReg(regDivisor, value);
		checkValue(value, divisorReset, "divisor after reset");
		readReg(regStatus, value);
		checkValue(value, expStatus, "status after reset");
	endtask

	task automatic loopbackBytes();
		logic [7:0] got;
		setDivisor(8'd1);
		writeReg(regCtrl, ctrlWord(1'b1, 1'b1, 1'b1, 1'b0));
		sent.delete();
		for (int i = 0; i < 6; i++)
		begin
			sent.push_back(8'($random(seed)));
			pushTx(sent[i]);
		end
		for (int i = 0; i < 6; i++)
		begin
			popRx(got);
			checkValue(got, sent[i], $sformatf("loopback byte %0d", i));
		end
	endtask

	task automatic externalLink();
		logic [7:0] got;
		writeReg(regCtrl, ctrlWord(1'b1, 1'b1, 1'b0, 1'b0)); // rx from the pin
		sent.delete();
		for (int i = 0; i < 3; i++)
		begin
			sent.push_back(8'($random(seed)));
			sendFrame(sent[i], 1'b1);
		end
		for (int i = 0; i < 3; i++)
		begin
			popRx(got);
			checkValue(got, sent[i], $sformatf("byte %0d received from rx pin", i));
		end
		sent.push_back(8'($random(seed)));
		pushTx(sent[3]);
		decodeFrame(got);
		checkValue(got, sent[3], "byte decoded from tx pin");
	endtask

	task automatic frameErrorFlag();
		uartStatus_t status, mask;
		logic [7:0]  value;
		// one tick per clock, line high again before the restart check at mid start
		setDivisor(8'd0);
		sendFrame(8'($random(seed)), 1'b0);
		mask            = '0;
		mask.frameError = 1'b1;
		pollStatus(mask, value);
		waitClocks(10 * bitClocks);            // a late byte would land within a frame
		checkValue(8'(rxValid), 8'd0, "rx byte from a frame with a low stop bit");
		readReg(regStatus, value);
		status = value;
		checkValue(8'(status.frameError), 8'd1, "frameError flag after bad stop bit");
		writeReg(regCtrl, ctrlWord(1'b1, 1'b1, 1'b0, 1'b1));
		readReg(regStatus, value);
		status = value;
		checkValue(8'(status.frameError), 8'd0, "frameError flag after clearErrors");
		readReg(regCtrl, value);
		checkValue(value, ctrlWord(1'b1, 1'b1, 1'b0, 1'b0), "control after clearErrors");
	endtask

	task automatic overrunDrain();
		uartStatus_t status, mask;
		logic [7:0]  value, got;
		setDivisor(8'd1);
		writeReg(regCtrl, ctrlWord(1'b1, 1'b1, 1'b1, 1'b0));
		sent.delete();
		for (int i = 0; i < fifoDepth + 2; i++)
			sent.push_back(8'($random(seed)));
		sawTxStall = 1'b0;
		rxReady    = 1'b0;                     // host reads nothing yet
		fork
			for (int i = 0; i < fifoDepth + 2; i++)
				pushTx(sent[i]);
			for (int j = 0; j < fifoDepth + 2; j++)
			begin
				decodeFrame(got);
				checkValue(got, sent[j], $sformatf("tx byte %0d under back-pressure", j));
			end
		join
		mask        = '0;
		mask.txIdle = 1'b1;
		pollStatus(mask, value);               // last stop bit done
		status = value;
		checkValue(8'(sawTxStall), 8'd1, "txReady low at least once");
		checkValue(8'(status.overrun), 8'd1, "overrun flag after rx FIFO filled");
		checkValue(8'(status.rxNotEmpty), 8'd1, "rxNotEmpty with a full rx FIFO");
		for (int i = 0; i < fifoDepth; i++)
		begin
			popRx(got);
			checkValue(got, sent[i], $sformatf("buffered rx byte %0d", i));
		end
		checkValue(8'(rxValid), 8'd0, "rx bytes beyond the FIFO depth");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	initial
	begin
		seed       = 32'h360d_08d0;
		errorCount = 0;
		checkCount = 0;
		bitClocks  = oversample * (int'(divisorReset) + 1);
		sawTxStall = 1'b0;
		reset      = 1'b1;
		rx         = 1'b1;    // line idles high
		reqValid   = 1'b0;
		req        = '0;
		txValid    = 1'b0;
		txData     = '0;
		rxReady    = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		resetState();
		loopbackBytes();
		externalLink();
		frameErrorFlag();
		overrunDrain();

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
